// File: list.f
hdl/bus_pkg.sv
hdl/read_client_if.sv
hdl/refill_arbiter.sv
hdl/axi_read_engine.sv
hdl/beat_collector.sv
hdl/bus_bridge_top.sv
test/tb_axi_mem.sv
test/tb_bus_bridge.sv

// File: Bender.yml
package:
  name: bus_bridge

sources:
  - hdl/bus_pkg.sv
  - hdl/read_client_if.sv
  - hdl/refill_arbiter.sv
  - hdl/axi_read_engine.sv
  - hdl/beat_collector.sv
  - hdl/bus_bridge_top.sv
  - target: test
    files:
      - test/tb_axi_mem.sv
      - test/tb_bus_bridge.sv

// File: test/tb_bus_bridge.sv
`timescale 1ns/1ps

module tb_bus_bridge;
    import bus_pkg::*;

    localparam int MAX_OUT = 2;
    localparam int TIMEOUT = 1000;  // cycles per wait

    logic       aclk;
    logic       rst_n;
    logic [2:0] req;
    addr_t      addr [3];
    logic [2:0] rdy;
    logic [2:0] ret_valid;
    line_t      ic_ret_data;
    line_t      dc_ret_data;
    word_t      uc_ret_data;
    axi_id_t    arid;
    addr_t      araddr;
    axi_len_t   arlen;
    axi_size_t  arsize;
    axi_burst_t arburst;
    logic       arvalid;
    logic       arready;
    axi_id_t    rid;
    word_t      rdata;
    logic       rlast;
    logic       rvalid;
    logic       rready;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests;
    int          errors_before;
    logic [2:0]  inflight;
    logic [2:0]  acc;
    int          rr_ptr;     // model of the round-robin pointer
    int          exp_grant;
    int          ar_out;
    int          ar_peak;
    axi_id_t     exp_id [$];
    addr_t       exp_addr [$];
    axi_len_t    exp_len [$];

    bus_bridge_top #(.MAX_OUTSTANDING(MAX_OUT)) i_bus_bridge_top (
        .aclk(aclk), .rst_n(rst_n),
        .ic_rd_req(req[0]), .ic_rd_addr(addr[0]), .ic_rd_rdy(rdy[0]),
        .ic_ret_valid(ret_valid[0]), .ic_ret_data(ic_ret_data),
        .dc_rd_req(req[1]), .dc_rd_addr(addr[1]), .dc_rd_rdy(rdy[1]),
        .dc_ret_valid(ret_valid[1]), .dc_ret_data(dc_ret_data),
        .uc_rd_req(req[2]), .uc_rd_addr(addr[2]), .uc_rd_rdy(rdy[2]),
        .uc_ret_valid(ret_valid[2]), .uc_ret_data(uc_ret_data),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready), .rid(rid), .rdata(rdata), .rlast(rlast),
        .rvalid(rvalid), .rready(rready)
    );

    tb_axi_mem #(.SEED(32'h6c62d6d0)) i_mem (
        .aclk(aclk), .rst_n(rst_n), .arid(arid), .araddr(araddr), .arlen(arlen),
        .arvalid(arvalid), .arready(arready), .rid(rid), .rdata(rdata), .rlast(rlast),
        .rvalid(rvalid), .rready(rready)
    );

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    function automatic logic [31:0] next_random();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // word at byte address a reads back as a ^ 5a5a0000
    function automatic word_t expected_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic line_t expected_line(input addr_t a);
        line_t l;
        addr_t base;
        base = a & 32'hffff_fff0;
        for (int b = 0; b < 4; b++)
            l[b*32 +: 32] = expected_word(base + 32'(4 * b));
        return l;
    endfunction

    task automatic report_error(input string msg);
        $display("%s (at %0t)", msg, $time);
        errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-22s %s, %0d errors", name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
        tests++;
        errors_before = errors;
    endtask

    // one full request from acceptance to the checked return
    task automatic issue_read(input int c, input addr_t a);
        int   n;
        logic got;
        @(posedge aclk);
        req[c]  <= 1'b1;
        addr[c] <= a;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            got = rdy[c];
        end while (!got && n < TIMEOUT);
        req[c] <= 1'b0;
        if (!got) begin
            report_error($sformatf("requester %0d was never accepted", c));
            return;
        end
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            got = ret_valid[c];
        end while (!got && n < TIMEOUT);
        if (!got)
            report_error($sformatf("requester %0d got no ret_valid", c));
        else if (c == 0)
            check_line("ic_ret_data", ic_ret_data, expected_line(a));
        else if (c == 1)
            check_line("dc_ret_data", dc_ret_data, expected_line(a));
        else
            check_word("uc_ret_data", uc_ret_data, expected_word(a));
    endtask

    task automatic run_traffic(input int c, input int count, input bit gaps);
        addr_t a;
        repeat (count) begin
            if (gaps)
                repeat ((next_random() >> 28) % 4) @(posedge aclk);
            a = next_random() & 32'hffff_fffc;
            issue_read(c, a);
        end
    endtask

    // protocol, credit and fairness monitor at the AXI and requester ports
    always @(posedge aclk) begin
        if (rst_n) begin
            acc = req & rdy;
            if (acc != '0) begin
                // first idle requester at or after the pointer wins
                exp_grant = -1;
                for (int k = 0; k < 3; k++) begin
                    if (exp_grant < 0 && req[(rr_ptr + k) % 3] && !inflight[(rr_ptr + k) % 3])
                        exp_grant = (rr_ptr + k) % 3;
                end
            end
            for (int i = 0; i < 3; i++) begin
                if (acc[i]) begin
                    check_word("granted requester", word_t'(i), word_t'(exp_grant));
                    rr_ptr = (i + 1) % 3;
                    exp_id.push_back(axi_id_t'(i));
                    exp_addr.push_back((i == 2) ? addr[i] : (addr[i] & 32'hffff_fff0));
                    exp_len.push_back((i == 2) ? 4'd0 : 4'd3);
                    inflight[i] = 1'b1;
                end
                if (ret_valid[i] && !inflight[i])
                    report_error($sformatf("ret_valid on requester %0d with no read in flight", i));
                if (ret_valid[i])
                    inflight[i] = 1'b0;
            end
            if (arvalid && arready) begin
                if (exp_id.size() == 0) begin
                    report_error("AR handshake without an accepted request");
                end else begin
                    check_word("arid", word_t'(arid), word_t'(exp_id.pop_front()));
                    check_word("araddr", araddr, exp_addr.pop_front());
                    check_word("arlen", word_t'(arlen), word_t'(exp_len.pop_front()));
                    check_word("arsize", word_t'(arsize), 32'd2);
                    check_word("arburst", word_t'(arburst), 32'd1);
                end
                ar_out++;
            end
            if (rvalid && rlast)
                ar_out--;
            if (ar_out > MAX_OUT)
                report_error($sformatf("%0d reads in flight on the AXI side", ar_out));
            if (ar_out > ar_peak)
                ar_peak = ar_out;
        end
    end

    initial begin
        rng = 32'h6c62d6d0;
        errors = 0;
        checks = 0;
        tests = 0;
        errors_before = 0;
        inflight = '0;
        rr_ptr = 0;
        exp_grant = 0;
        ar_out = 0;
        ar_peak = 0;
        for (int i = 0; i < 3; i++) begin
            addr[i] = '0;
        end
        rst_n = 1'b0;
        req = '0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;

        @(posedge aclk);
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("ic_ret_valid", ret_valid[0], 1'b0);
        check_bit("dc_ret_valid", ret_valid[1], 1'b0);
        check_bit("uc_ret_valid", ret_valid[2], 1'b0);
        check_bit("rready", rready, 1'b1);
        finish_test("reset");

        issue_read(0, next_random() & 32'hffff_fffc);
        finish_test("icache refill");

        issue_read(2, (next_random() & 32'hffff_fff0) | 32'h4);  // not line aligned
        finish_test("uncached read");

        fork
            run_traffic(0, 10, 1'b1);
            run_traffic(1, 10, 1'b1);
            run_traffic(2, 10, 1'b1);
        join
        finish_test("random traffic");

        check_bit("peak within credits", ar_peak <= MAX_OUT, 1'b1);
        $display("peak reads in flight %0d", ar_peak);
        finish_test("credit limit");

        // leaves the pointer on the dcache before the three-way start
        issue_read(0, next_random() & 32'hffff_fffc);
        fork
            run_traffic(0, 6, 1'b0);
            run_traffic(1, 6, 1'b0);
            run_traffic(2, 6, 1'b0);
        join
        finish_test("fairness");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: test/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter logic [31:0] SEED = 32'h6c62d6d0
) (
    input  logic             aclk,
    input  logic             rst_n,
    input  bus_pkg::axi_id_t arid,
    input  bus_pkg::addr_t   araddr,
    input  bus_pkg::axi_len_t arlen,
    input  logic             arvalid,
    output logic             arready,
    output bus_pkg::axi_id_t rid,
    output bus_pkg::word_t   rdata,
    output logic             rlast,
    output logic             rvalid,
    input  logic             rready
);
    import bus_pkg::*;

    axi_id_t     pend_id [$];    // accepted reads, not fully returned
    addr_t       pend_addr [$];  // address of the next beat
    int          pend_left [$];
    logic [31:0] rng;
    int          pick;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rng = SEED;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rid     <= '0;
            rdata   <= '0;
            pend_id.delete();
            pend_addr.delete();
            pend_left.delete();
        end else begin
            if (arvalid && arready) begin
                pend_id.push_back(arid);
                pend_addr.push_back(araddr);
                pend_left.push_back(int'(arlen) + 1);
            end
            rng = lcg_step(rng);
            arready <= (rng[31:30] != 2'b00);  // stall about one cycle in four
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            // any pending read may answer next, so ids come back out of order
            if (rready && pend_id.size() != 0 && rng[29:28] != 2'b00) begin
                pick = int'(rng[27:16]) % pend_id.size();
                rid    <= pend_id[pick];
                rdata  <= pend_addr[pick] ^ 32'h5a5a_0000;
                rvalid <= 1'b1;
                rlast  <= (pend_left[pick] == 1);
                pend_addr[pick] = pend_addr[pick] + 32'd4;
                pend_left[pick] = pend_left[pick] - 1;
                if (pend_left[pick] == 0) begin
                    pend_id.delete(pick);
                    pend_addr.delete(pick);
                    pend_left.delete(pick);
                end
            end
        end
    end

endmodule

// File: hdl/bus_bridge_top.sv
`timescale 1ns/1ps

module bus_bridge_top #(
    parameter int MAX_OUTSTANDING = 2
) (
    input  logic                aclk,
    input  logic                rst_n,
    // icache refill
    input  logic                ic_rd_req,
    input  bus_pkg::addr_t      ic_rd_addr,
    output logic                ic_rd_rdy,
    output logic                ic_ret_valid,
    output bus_pkg::line_t      ic_ret_data,
    // dcache refill
    input  logic                dc_rd_req,
    input  bus_pkg::addr_t      dc_rd_addr,
    output logic                dc_rd_rdy,
    output logic                dc_ret_valid,
    output bus_pkg::line_t      dc_ret_data,
    // uncached word read
    input  logic                uc_rd_req,
    input  bus_pkg::addr_t      uc_rd_addr,
    output logic                uc_rd_rdy,
    output logic                uc_ret_valid,
    output bus_pkg::word_t      uc_ret_data,
    // AXI read channels
    output bus_pkg::axi_id_t    arid,
    output bus_pkg::addr_t      araddr,
    output bus_pkg::axi_len_t   arlen,
    output bus_pkg::axi_size_t  arsize,
    output bus_pkg::axi_burst_t arburst,
    output logic                arvalid,
    input  logic                arready,
    input  bus_pkg::axi_id_t    rid,
    input  bus_pkg::word_t      rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);
    import bus_pkg::*;

    logic [NUM_CLIENTS-1:0] ret_done;
    logic                   issue_valid;
    axi_id_t                issue_id;
    addr_t                  issue_addr;
    axi_len_t               issue_len;
    logic                   credit_return;

    read_client_if client_if [NUM_CLIENTS] ();

    assign client_if[CLIENT_ICACHE].rd_req    = ic_rd_req;
    assign client_if[CLIENT_ICACHE].rd_addr   = ic_rd_addr;
    assign client_if[CLIENT_DCACHE].rd_req    = dc_rd_req;
    assign client_if[CLIENT_DCACHE].rd_addr   = dc_rd_addr;
    assign client_if[CLIENT_UNCACHED].rd_req  = uc_rd_req;
    assign client_if[CLIENT_UNCACHED].rd_addr = uc_rd_addr;
    assign ic_rd_rdy = client_if[CLIENT_ICACHE].rd_rdy;
    assign dc_rd_rdy = client_if[CLIENT_DCACHE].rd_rdy;
    assign uc_rd_rdy = client_if[CLIENT_UNCACHED].rd_rdy;

    // R channel fan-out, rid is the client index
    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_rfan
        assign client_if[i].beat_valid = rvalid && (rid == axi_id_t'(i));
        assign client_if[i].beat_data  = rdata;
        assign client_if[i].beat_last  = rlast;
    end

    assign ret_done[CLIENT_ICACHE]   = ic_ret_valid;
    assign ret_done[CLIENT_DCACHE]   = dc_ret_valid;
    assign ret_done[CLIENT_UNCACHED] = uc_ret_valid;

    refill_arbiter #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_refill_arbiter (
        .aclk(aclk), .rst_n(rst_n), .clients(client_if), .done(ret_done),
        .credit_return(credit_return), .issue_valid(issue_valid),
        .issue_id(issue_id), .issue_addr(issue_addr), .issue_len(issue_len)
    );

    axi_read_engine #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_axi_read_engine (
        .aclk(aclk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_id(issue_id),
        .issue_addr(issue_addr), .issue_len(issue_len), .credit_return(credit_return),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rlast(rlast),
        .rready(rready)
    );

    beat_collector #(.payload_t(line_t)) i_ic_collector (
        .aclk(aclk), .rst_n(rst_n), .beats(client_if[CLIENT_ICACHE]),
        .ret_valid(ic_ret_valid), .ret_data(ic_ret_data)
    );

    beat_collector #(.payload_t(line_t)) i_dc_collector (
        .aclk(aclk), .rst_n(rst_n), .beats(client_if[CLIENT_DCACHE]),
        .ret_valid(dc_ret_valid), .ret_data(dc_ret_data)
    );

    beat_collector #(.payload_t(word_t)) i_uc_collector (
        .aclk(aclk), .rst_n(rst_n), .beats(client_if[CLIENT_UNCACHED]),
        .ret_valid(uc_ret_valid), .ret_data(uc_ret_data)
    );

endmodule

// File: hdl/beat_collector.sv
`timescale 1ns/1ps

module beat_collector #(
    parameter type payload_t = bus_pkg::line_t
) (
    input  logic            aclk,
    input  logic            rst_n,
    read_client_if.collect  beats,
    output logic            ret_valid,
    output payload_t        ret_data
);
    import bus_pkg::*;

    localparam int WORD_W    = $bits(word_t);
    localparam int NUM_SLOTS = $bits(payload_t) / WORD_W;
    localparam int CNT_W     = $clog2(LINE_BEATS);

    logic [CNT_W-1:0] beat_cnt;
    logic [CNT_W-1:0] slot;

    // a word payload always lands in slot 0
    assign slot = (NUM_SLOTS > 1) ? beat_cnt : '0;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt  <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= beats.beat_valid && beats.beat_last;
            if (beats.beat_valid)
                beat_cnt <= beats.beat_last ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (beats.beat_valid)
            ret_data[slot*WORD_W +: WORD_W] <= beats.beat_data;
    end

    if (NUM_SLOTS > 1) begin : g_line_check
        // slave must end every line burst on beat four
        assert property (@(posedge aclk) disable iff (!rst_n)
            beats.beat_valid |-> (beats.beat_last == (beat_cnt == CNT_W'(LINE_BEATS - 1))));
    end

endmodule

// File: hdl/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine #(
    parameter int MAX_OUTSTANDING = 2
) (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  bus_pkg::axi_id_t    issue_id,
    input  bus_pkg::addr_t      issue_addr,
    input  bus_pkg::axi_len_t   issue_len,
    output logic                credit_return,
    output bus_pkg::axi_id_t    arid,
    output bus_pkg::addr_t      araddr,
    output bus_pkg::axi_len_t   arlen,
    output bus_pkg::axi_size_t  arsize,
    output bus_pkg::axi_burst_t arburst,
    output logic                arvalid,
    input  logic                arready,
    input  logic                rvalid,
    input  logic                rlast,
    output logic                rready
);
    import bus_pkg::*;

    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    typedef struct packed {
        axi_id_t  id;
        addr_t    addr;
        axi_len_t len;
    } ar_entry_t;

    ar_entry_t        fifo_q [MAX_OUTSTANDING];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge aclk) begin
        if (issue_valid)
            fifo_q[wr_ptr] <= '{id: issue_id, addr: issue_addr, len: issue_len};
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (issue_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({issue_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // head entry stays put until arready
    assign arvalid = (count != '0);
    assign pop     = arvalid && arready;
    assign arid    = fifo_q[rd_ptr].id;
    assign araddr  = fifo_q[rd_ptr].addr;
    assign arlen   = fifo_q[rd_ptr].len;
    assign arsize  = SIZE_WORD;
    assign arburst = BURST_INCR;

    assign rready        = 1'b1;  // collectors never stall
    assign credit_return = rvalid && rlast;

    // the arbiter's credits must keep the queue from overflowing
    assert property (@(posedge aclk) disable iff (!rst_n)
        issue_valid |-> (count < MAX_OUTSTANDING));

endmodule

// File: hdl/refill_arbiter.sv
`timescale 1ns/1ps

module refill_arbiter #(
    parameter int MAX_OUTSTANDING = 2
) (
    input  logic                              aclk,
    input  logic                              rst_n,
    read_client_if.arb                        clients [bus_pkg::NUM_CLIENTS],
    input  logic [bus_pkg::NUM_CLIENTS-1:0]   done,
    input  logic                              credit_return,
    output logic                              issue_valid,
    output bus_pkg::axi_id_t                  issue_id,
    output bus_pkg::addr_t                    issue_addr,
    output bus_pkg::axi_len_t                 issue_len
);
    import bus_pkg::*;

    localparam int CREDIT_W = $clog2(MAX_OUTSTANDING + 1);

    logic [NUM_CLIENTS-1:0] req;
    logic [NUM_CLIENTS-1:0] rdy;
    logic [NUM_CLIENTS-1:0] busy;
    logic [NUM_CLIENTS-1:0] eligible;
    addr_t                  addr [NUM_CLIENTS];
    logic [CREDIT_W-1:0]    credits;
    client_e                ptr;   // round-robin start point
    client_e                pick;
    logic                   found;
    logic                   grant;

    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_client
        assign req[i]            = clients[i].rd_req;
        assign addr[i]           = clients[i].rd_addr;
        assign clients[i].rd_rdy = rdy[i];
        assign eligible[i]       = req[i] & ~busy[i];
        assign rdy[i]            = grant && (pick == i);

        // once accepted, no second request until the line comes back
        assert property (@(posedge aclk) disable iff (!rst_n)
            (req[i] && rdy[i]) |=> !rdy[i] until_with done[i]);
    end

    // first eligible requester at or after the pointer
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = ptr;
        for (int k = 0; k < NUM_CLIENTS; k++) begin
            cand = int'(ptr) + k;
            if (cand >= NUM_CLIENTS)
                cand = cand - NUM_CLIENTS;
            if (!found && eligible[cand]) begin
                found = 1'b1;
                pick  = client_e'(cand);
            end
        end
    end

    assign grant       = found && (credits != '0);
    assign issue_valid = grant;
    assign issue_id    = axi_id_t'(pick);
    assign issue_len   = (pick == CLIENT_UNCACHED) ? axi_len_t'(0) : axi_len_t'(LINE_BEATS - 1);
    assign issue_addr  = (pick == CLIENT_UNCACHED) ? addr[pick] :
                         (addr[pick] & ~addr_t'(LINE_BEATS * $bits(word_t) / 8 - 1));

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(MAX_OUTSTANDING);
            busy    <= '0;
            ptr     <= CLIENT_ICACHE;
        end else begin
            case ({grant, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;  // none, or spend and return together
            endcase
            busy <= (busy | rdy) & ~done;
            if (grant)
                ptr <= (pick == client_e'(NUM_CLIENTS - 1)) ? CLIENT_ICACHE : client_e'(pick + 1);
        end
    end

    // more returns than grants would mean a lost or duplicated rlast
    assert property (@(posedge aclk) disable iff (!rst_n) credits <= MAX_OUTSTANDING);

endmodule

// File: hdl/read_client_if.sv
`timescale 1ns/1ps

interface read_client_if;
    import bus_pkg::*;

    // request side
    logic  rd_req;
    addr_t rd_addr;
    logic  rd_rdy;

    // return side, already filtered by rid
    logic  beat_valid;
    word_t beat_data;
    logic  beat_last;

    modport arb (
        input  rd_req,
        input  rd_addr,
        output rd_rdy
    );

    modport collect (
        input beat_valid,
        input beat_data,
        input beat_last
    );

endinterface

// File: hdl/bus_pkg.sv
package bus_pkg;

    // beat and line geometry
    localparam int NUM_CLIENTS = 3;
    localparam int LINE_BEATS  = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // beat 0 sits in the low bits
    typedef logic [LINE_BEATS*$bits(word_t)-1:0] line_t;

    // AR channel fields
    typedef logic [3:0] axi_id_t;
    typedef logic [3:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;

    // requester index, doubles as the AXI read ID
    typedef enum logic [1:0] {
        CLIENT_ICACHE   = 2'd0,
        CLIENT_DCACHE   = 2'd1,
        CLIENT_UNCACHED = 2'd2
    } client_e;

    localparam axi_size_t  SIZE_WORD  = 3'd2;  // 4 bytes per beat
    localparam axi_burst_t BURST_INCR = 2'd1;

endpackage
